//--- Bender.yml
package:
  name: trap_controller

sources:
  - source/trap_ctrl_pkg.sv
  - source/exc_req_if.sv
  - source/irq_req_if.sv
  - source/exc_prio_unit.sv
  - source/irq_arbiter.sv
  - source/ctrl_fsm.sv
  - source/trap_controller.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_trap_controller.sv

//--- source/ctrl_fsm.sv
/*
  controller FSM: boot, decode, flush, interrupt redirect
  and sleep; pc and csr strobes, nmi mode, id stall and flush
*/

`timescale 1ns/10ps

module ctrl_fsm import trap_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       instr_valid_i,
  input  logic       stall_id_i,
  input  logic       branch_set_i,
  input  logic       jump_set_i,
  exc_req_if.fsm     req,
  irq_req_if.fsm     irq,
  output logic       ctrl_busy_o,
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_sel_t    pc_mux_o,
  output exc_cause_t exc_cause_o,
  output word_t      csr_mtval_o,
  output logic       csr_save_if_o,
  output logic       csr_save_id_o,
  output logic       csr_save_cause_o,
  output logic       csr_restore_mret_o,
  output logic       nmi_mode_o,
  output logic       flush_id_o,
  output logic       id_in_ready_o,
  output logic       instr_valid_clear_o
);

  ctrl_state_e state_q, state_d;
  logic        nmi_mode_q, nmi_mode_d;
  logic        halt_if, retain_id, flush_id;

  assign req.in_flush = (state_q == FLUSH);

  //////////////////////////////////////////////////
  // next state and strobes
  //////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    nmi_mode_d         = nmi_mode_q;
    instr_req_o        = 1'b1;
    ctrl_busy_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_cause_o        = '0;
    csr_mtval_o        = '0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    halt_if            = 1'b0;
    retain_id          = 1'b0;
    flush_id           = 1'b0;

    unique case (state_q)
      RESET: begin
        // boot address, no fetch yet
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        halt_if     = 1'b1;
        state_d     = BOOT_SET;
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        halt_if  = 1'b1;
        state_d  = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        if (irq.wake) begin
          state_d = FIRST_FETCH;
        end else begin
          // keep the clock gated
          ctrl_busy_o = 1'b0;
        end
      end
      FIRST_FETCH: begin
        // wait here while IF misses
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        // stop fetching, redirect once ID is empty
        if (irq.handle_irq) begin
          halt_if = 1'b1;
          if (!instr_valid_i && !stall_id_i) begin
            state_d = IRQ_TAKEN;
          end
        end
      end
      DECODE: begin
        // mux set early, only used with pc_set_o
        pc_mux_o = PC_JUMP;
        // keep the instruction in ID for FLUSH to inspect
        if (req.special_req) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        if (branch_set_i || jump_set_i) begin
          pc_set_o = 1'b1;
        end
        // drain the pipeline before the interrupt redirect
        if (irq.handle_irq && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end
        if (irq.handle_irq && !stall_id_i && !req.special_req && !instr_valid_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end
      IRQ_TAKEN: begin
        pc_mux_o = PC_EXC;
        // line may have dropped meanwhile, then just resume
        if (irq.handle_irq) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq.irq_cause;
          if (irq.take_nmi) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (req.exc_pending) begin
          // trap to handler, mepc from the ID stage
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = req.exc_cause;
          csr_mtval_o      = req.exc_mtval;
        end else if (req.mret) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_restore_mret_o = 1'b1;
          // leaving the nmi handler
          nmi_mode_d         = 1'b0;
        end else if (req.wfi) begin
          state_d = WAIT_SLEEP;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // id stage handshake
  //////////////////////////////////////////////////

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;
  // retain keeps the valid bit unless a flush overrides it
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o = flush_id;

  assign nmi_mode_o   = nmi_mode_q;
  assign irq.nmi_mode = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

endmodule

//--- source/exc_prio_unit.sv
/*
  exception prioritiser: qualifies decoder flags, holds the
  exception request and lsu errors, selects cause and mtval
*/

`timescale 1ns/10ps

module exc_prio_unit import trap_ctrl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    instr_valid_i,
  input  logic                    illegal_insn_i,
  input  logic                    ecall_insn_i,
  input  logic                    ebrk_insn_i,
  input  logic                    mret_insn_i,
  input  logic                    wfi_insn_i,
  input  logic                    instr_fetch_err_i,
  input  logic                    instr_fetch_err_plus2_i,
  input  logic                    instr_is_compressed_i,
  input  logic                    load_err_i,
  input  logic                    store_err_i,
  input  word_t                   instr_i,
  input  word_t                   pc_id_i,
  input  word_t                   lsu_addr_last_i,
  input  logic [COMPRESSED_W-1:0] instr_compressed_i,
  input  priv_lvl_t               priv_mode_i,
  exc_req_if.unit                 req
);

  logic ecall_insn, ebrk_insn, fetch_err;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_q, store_err_q;

  // decoder flags only count with a valid instruction
  assign ecall_insn = ecall_insn_i & instr_valid_i;
  assign ebrk_insn  = ebrk_insn_i & instr_valid_i;
  assign fetch_err  = instr_fetch_err_i & instr_valid_i;
  assign req.mret   = mret_insn_i & instr_valid_i;
  assign req.wfi    = wfi_insn_i & instr_valid_i;

  // dropped once FLUSH has handled them
  assign illegal_d = illegal_insn_i & instr_valid_i & ~req.in_flush;
  assign exc_req_d = (ecall_insn | ebrk_insn | illegal_d | fetch_err) & ~req.in_flush;

  // flush-only and pc-changing requests, lsu errors come without a valid instruction
  assign req.special_req = exc_req_d | req.mret | req.wfi | load_err_i | store_err_i;
  assign req.exc_pending = exc_req_q | load_err_q | store_err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_i & ~req.in_flush;
      store_err_q <= store_err_i & ~req.in_flush;
    end
  end

  //////////////////////////////////////////////////
  // priority chain, first hit wins
  //////////////////////////////////////////////////

  always_comb begin
    req.exc_cause = '0;
    req.exc_mtval = '0;
    if (fetch_err) begin
      req.exc_cause = EXC_CAUSE_FETCH_FAULT;
      // second half of an unaligned instruction faulted
      req.exc_mtval = instr_fetch_err_plus2_i ? pc_id_i + word_t'(2) : pc_id_i;
    end else if (illegal_q) begin
      req.exc_cause = EXC_CAUSE_ILLEGAL;
      req.exc_mtval = instr_is_compressed_i ? word_t'(instr_compressed_i) : instr_i;
    end else if (ecall_insn) begin
      req.exc_cause = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_M : EXC_CAUSE_ECALL_U;
    end else if (ebrk_insn) begin
      req.exc_cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      req.exc_cause = EXC_CAUSE_STORE_FAULT;
      req.exc_mtval = lsu_addr_last_i;
    end else if (load_err_q) begin
      req.exc_cause = EXC_CAUSE_LOAD_FAULT;
      req.exc_mtval = lsu_addr_last_i;
    end
  end

endmodule

//--- source/exc_req_if.sv
/*
  exception and special instruction requests,
  prioritiser towards controller FSM
*/

`timescale 1ns/10ps

interface exc_req_if import trap_ctrl_pkg::*; ();

  // valid special instruction or lsu error this cycle
  logic       special_req;
  // registered exception request
  logic       exc_pending;
  // winning exception of the current cycle
  exc_cause_t exc_cause;
  word_t      exc_mtval;
  logic       mret;
  logic       wfi;
  // controller is in FLUSH
  logic       in_flush;

  modport unit (output special_req, exc_pending, exc_cause, exc_mtval, mret, wfi,
                input  in_flush);

  modport fsm  (input  special_req, exc_pending, exc_cause, exc_mtval, mret, wfi,
                output in_flush);

endinterface

//--- source/irq_arbiter.sv
/*
  interrupt arbiter: enable check, nmi gating, cause
  selection and wake-up from sleep
*/

`timescale 1ns/10ps

module irq_arbiter import trap_ctrl_pkg::*; (
  input  logic      irq_nm_i,
  input  logic      irq_software_i,
  input  logic      irq_timer_i,
  input  logic      irq_external_i,
  input  fast_irq_t irq_fast_i,
  input  logic      csr_mstatus_mie_i,
  input  priv_lvl_t priv_mode_i,
  irq_req_if.arbiter irq
);

  logic       irq_enabled;
  logic       irq_pending;
  logic       fast_any;
  logic [3:0] fast_id;

  //////////////////////////////////////////////////
  // decision
  //////////////////////////////////////////////////

  // mie only masks in M mode, U mode is always interruptible
  assign irq_enabled = csr_mstatus_mie_i | (priv_mode_i == PRIV_LVL_U);

  assign fast_any    = |irq_fast_i;
  assign irq_pending = fast_any | irq_external_i | irq_software_i | irq_timer_i;

  // no nesting inside the nmi handler, not even another nmi
  assign irq.handle_irq = ~irq.nmi_mode & (irq_nm_i | (irq_pending & irq_enabled));
  assign irq.take_nmi   = irq_nm_i & ~irq.nmi_mode;

  // sleep ends on any line, enabled or not
  assign irq.wake = irq_nm_i | irq_pending;

  //////////////////////////////////////////////////
  // cause
  //////////////////////////////////////////////////

  // lowest fast index wins, scan downwards so it is written last
  always_comb begin
    fast_id = '0;
    for (int i = NUM_FAST_IRQ - 1; i >= 0; i--) begin
      if (irq_fast_i[i]) begin
        fast_id = 4'(i);
      end
    end
  end

  // nmi, fast, external, software, timer
  always_comb begin
    if (irq.take_nmi) begin
      irq.irq_cause = IRQ_CAUSE_NMI;
    end else if (fast_any) begin
      irq.irq_cause = IRQ_CAUSE_FAST_BASE + {2'b00, fast_id};
    end else if (irq_external_i) begin
      irq.irq_cause = IRQ_CAUSE_EXTERNAL;
    end else if (irq_software_i) begin
      irq.irq_cause = IRQ_CAUSE_SOFTWARE;
    end else begin
      // timer, or nothing pending and not looked at
      irq.irq_cause = IRQ_CAUSE_TIMER;
    end
  end

endmodule

//--- source/irq_req_if.sv
/*
  interrupt decision and cause, arbiter towards controller FSM
*/

`timescale 1ns/10ps

interface irq_req_if import trap_ctrl_pkg::*; ();

  // take an interrupt as soon as the pipeline is idle
  logic       handle_irq;
  // leave sleep, any nmi or raw pending line
  logic       wake;
  logic       take_nmi;
  exc_cause_t irq_cause;
  // core runs the nmi handler
  logic       nmi_mode;

  modport arbiter (output handle_irq, wake, take_nmi, irq_cause, input nmi_mode);

  modport fsm     (input handle_irq, wake, take_nmi, irq_cause, output nmi_mode);

endinterface

//--- source/trap_controller.sv
/*
  trap and flow controller top level, exception prioritiser
  and interrupt arbiter feeding the controller FSM
*/

`timescale 1ns/10ps

module trap_controller import trap_ctrl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // ID stage instruction and decoder flags
  input  logic                    instr_valid_i,
  input  word_t                   instr_i,
  input  logic [COMPRESSED_W-1:0] instr_compressed_i,
  input  logic                    instr_is_compressed_i,
  input  logic                    instr_fetch_err_i,
  input  logic                    instr_fetch_err_plus2_i,
  input  word_t                   pc_id_i,
  input  logic                    illegal_insn_i,
  input  logic                    ecall_insn_i,
  input  logic                    ebrk_insn_i,
  input  logic                    mret_insn_i,
  input  logic                    wfi_insn_i,
  // lsu errors
  input  word_t                   lsu_addr_last_i,
  input  logic                    load_err_i,
  input  logic                    store_err_i,
  // control flow and stall
  input  logic                    branch_set_i,
  input  logic                    jump_set_i,
  input  logic                    stall_id_i,
  // interrupts and csr state
  input  logic                    csr_mstatus_mie_i,
  input  priv_lvl_t               priv_mode_i,
  input  logic                    irq_nm_i,
  input  logic                    irq_software_i,
  input  logic                    irq_timer_i,
  input  logic                    irq_external_i,
  input  fast_irq_t               irq_fast_i,
  // towards IF, ID and CSRs
  output logic                    ctrl_busy_o,
  output logic                    instr_req_o,
  output logic                    pc_set_o,
  output pc_sel_t                 pc_mux_o,
  output exc_cause_t              exc_cause_o,
  output word_t                   csr_mtval_o,
  output logic                    csr_save_if_o,
  output logic                    csr_save_id_o,
  output logic                    csr_save_cause_o,
  output logic                    csr_restore_mret_o,
  output logic                    nmi_mode_o,
  output logic                    flush_id_o,
  output logic                    id_in_ready_o,
  output logic                    instr_valid_clear_o
);

  exc_req_if exc_req ();
  irq_req_if irq_req ();

  exc_prio_unit i_exc_prio_unit (.clk_i, .rst_ni, .instr_valid_i, .illegal_insn_i,
    .ecall_insn_i, .ebrk_insn_i, .mret_insn_i, .wfi_insn_i, .instr_fetch_err_i,
    .instr_fetch_err_plus2_i, .instr_is_compressed_i, .load_err_i, .store_err_i, .instr_i,
    .pc_id_i, .lsu_addr_last_i, .instr_compressed_i, .priv_mode_i, .req(exc_req.unit));

  irq_arbiter i_irq_arbiter (.irq_nm_i, .irq_software_i, .irq_timer_i, .irq_external_i,
    .irq_fast_i, .csr_mstatus_mie_i, .priv_mode_i, .irq(irq_req.arbiter));

  // sequencing and all outputs towards the pipeline
  ctrl_fsm i_ctrl_fsm (.clk_i, .rst_ni, .instr_valid_i, .stall_id_i, .branch_set_i,
    .jump_set_i, .req(exc_req.fsm), .irq(irq_req.fsm), .ctrl_busy_o, .instr_req_o, .pc_set_o,
    .pc_mux_o, .exc_cause_o, .csr_mtval_o, .csr_save_if_o, .csr_save_id_o, .csr_save_cause_o,
    .csr_restore_mret_o, .nmi_mode_o, .flush_id_o, .id_in_ready_o, .instr_valid_clear_o);

endmodule

//--- source/trap_ctrl_pkg.sv
/*
  widths, cause codes, pc selectors and privilege codes
  for the trap and flow controller, plus the FSM state enum
*/

package trap_ctrl_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // data word width of the core
  localparam int unsigned XLEN = 32;
  // number of fast interrupt lines
  localparam int unsigned NUM_FAST_IRQ = 15;
  // width of a compressed instruction
  localparam int unsigned COMPRESSED_W = 16;

  // pc, instruction word and mtval
  typedef logic [XLEN-1:0] word_t;
  typedef logic [NUM_FAST_IRQ-1:0] fast_irq_t;

  //////////////////////////////////////////////////
  // trap causes
  //////////////////////////////////////////////////

  // bit 5 flags an interrupt, bits 4:0 hold the code
  typedef logic [5:0] exc_cause_t;

  localparam exc_cause_t EXC_CAUSE_FETCH_FAULT = 6'd1;
  localparam exc_cause_t EXC_CAUSE_ILLEGAL     = 6'd2;
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT  = 6'd3;
  localparam exc_cause_t EXC_CAUSE_LOAD_FAULT  = 6'd5;
  localparam exc_cause_t EXC_CAUSE_STORE_FAULT = 6'd7;
  localparam exc_cause_t EXC_CAUSE_ECALL_U     = 6'd8;
  localparam exc_cause_t EXC_CAUSE_ECALL_M     = 6'd11;
  localparam exc_cause_t IRQ_CAUSE_SOFTWARE    = 6'd35;
  localparam exc_cause_t IRQ_CAUSE_TIMER       = 6'd39;
  localparam exc_cause_t IRQ_CAUSE_EXTERNAL    = 6'd43;
  // fast line n maps to base + n
  localparam exc_cause_t IRQ_CAUSE_FAST_BASE   = 6'd48;
  localparam exc_cause_t IRQ_CAUSE_NMI         = 6'd63;

  // fetch address selector towards the IF stage
  typedef logic [1:0] pc_sel_t;

  localparam pc_sel_t PC_BOOT = 2'd0;
  localparam pc_sel_t PC_JUMP = 2'd1;
  localparam pc_sel_t PC_EXC  = 2'd2;
  localparam pc_sel_t PC_ERET = 2'd3;

  // privilege levels, only U and M exist
  typedef logic [1:0] priv_lvl_t;

  localparam priv_lvl_t PRIV_LVL_U = 2'd0;
  localparam priv_lvl_t PRIV_LVL_M = 2'd3;

  // controller states
  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, IRQ_TAKEN, FLUSH
  } ctrl_state_e;

endpackage

//--- test/tb_ctrl_model.svh
/*
  reference model for the trap controller testbench: expected
  exception cause and mtval, interrupt decision and cause, pc selector
*/

`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

// fetch fault, illegal, ecall, ebreak, store fault, load fault
function automatic exc_cause_t expected_exc_cause(input logic fetch_err, illegal, ecall, ebrk,
                                                  input logic store_err, load_err,
                                                  input priv_lvl_t priv);
  return fetch_err ? EXC_CAUSE_FETCH_FAULT :
         illegal   ? EXC_CAUSE_ILLEGAL :
         ecall     ? ((priv == PRIV_LVL_M) ? EXC_CAUSE_ECALL_M : EXC_CAUSE_ECALL_U) :
         ebrk      ? EXC_CAUSE_BREAKPOINT :
         store_err ? EXC_CAUSE_STORE_FAULT : EXC_CAUSE_LOAD_FAULT;
endfunction

// mtval of the winning exception, zero for ecall and ebreak
function automatic word_t expected_mtval(input logic fetch_err, plus2, illegal, compressed,
                                         input logic ecall, ebrk, lsu_err,
                                         input word_t insn, pc, addr,
                                         input logic [COMPRESSED_W-1:0] insn_c);
  word_t insn_c_ext;
  insn_c_ext = {{(XLEN - COMPRESSED_W){1'b0}}, insn_c};
  return fetch_err      ? (plus2 ? pc + 32'd2 : pc) :
         illegal        ? (compressed ? insn_c_ext : insn) :
         (ecall | ebrk) ? '0 :
         lsu_err        ? addr : '0;
endfunction

// nmi always, other lines only with mie set or from U mode
function automatic bit expected_irq_taken(input logic nmi, input fast_irq_t fast,
                                          input logic ext, sw, tmr, mie,
                                          input priv_lvl_t priv);
  logic lines;
  lines = (fast != '0) | ext | sw | tmr;
  return nmi | (lines & (mie | (priv == PRIV_LVL_U)));
endfunction

// nmi, lowest fast index, external, software, timer
function automatic exc_cause_t expected_irq_cause(input logic nmi, input fast_irq_t fast,
                                                  input logic ext, sw, tmr);
  exc_cause_t cause;
  bit         found;
  cause = ext ? IRQ_CAUSE_EXTERNAL : (sw ? IRQ_CAUSE_SOFTWARE : IRQ_CAUSE_TIMER);
  found = 1'b0;
  for (int i = 0; i < NUM_FAST_IRQ; i++) begin
    if (fast[i] && !found) begin
      cause = IRQ_CAUSE_FAST_BASE + exc_cause_t'(i);
      found = 1'b1;
    end
  end
  return nmi ? IRQ_CAUSE_NMI : cause;
endfunction

// fetch target for a boot, a trap, an mret or a branch or jump
function automatic pc_sel_t expected_pc_sel(input bit boot, trap, eret);
  return boot ? PC_BOOT : (trap ? PC_EXC : (eret ? PC_ERET : PC_JUMP));
endfunction

`endif

//--- test/tb_trap_controller.sv
/*
  testbench for the trap controller: clock, reset, LFSR stimulus,
  scenario tasks, checks against the model, watchdog and summary
*/

`timescale 1ns/10ps

module tb_trap_controller import trap_ctrl_pkg::*; ();

  localparam int CLK_PERIOD      = 20;
  localparam int DRIVE_DELAY     = 2;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_SCENARIOS   = 40;
  // 40 cycles per scenario plus reset and boot
  localparam int WATCHDOG_CYCLES = NUM_SCENARIOS * 40 + RESET_CYCLES + 6;

  logic clk_i, rst_ni;
  logic instr_valid_i, instr_is_compressed_i, instr_fetch_err_i, instr_fetch_err_plus2_i;
  logic illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, wfi_insn_i;
  logic load_err_i, store_err_i, branch_set_i, jump_set_i, stall_id_i;
  logic csr_mstatus_mie_i, irq_nm_i, irq_software_i, irq_timer_i, irq_external_i;
  word_t instr_i, pc_id_i, lsu_addr_last_i;
  logic [COMPRESSED_W-1:0] instr_compressed_i;
  priv_lvl_t priv_mode_i;
  fast_irq_t irq_fast_i;
  logic ctrl_busy_o, instr_req_o, pc_set_o, csr_save_if_o, csr_save_id_o, csr_save_cause_o;
  logic csr_restore_mret_o, nmi_mode_o, flush_id_o, id_in_ready_o, instr_valid_clear_o;
  pc_sel_t pc_mux_o;
  exc_cause_t exc_cause_o;
  word_t csr_mtval_o;

  logic [15:0] lfsr_state;
  int check_errors, errors_at_start, tests_passed, tests_failed;

  trap_controller i_trap_controller (.*);

  `include "tb_ctrl_model.svh"

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run aborted", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] random_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic clear_inputs();
    {instr_valid_i, instr_is_compressed_i, instr_fetch_err_i, instr_fetch_err_plus2_i} = '0;
    {illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, wfi_insn_i} = '0;
    {load_err_i, store_err_i, branch_set_i, jump_set_i, stall_id_i} = '0;
    {csr_mstatus_mie_i, irq_nm_i, irq_software_i, irq_timer_i, irq_external_i} = '0;
    {instr_i, pc_id_i, lsu_addr_last_i, instr_compressed_i, irq_fast_i} = '0;
    priv_mode_i = PRIV_LVL_M;
  endtask

  // inputs change shortly after the edge, outputs are read mid cycle
  task automatic wait_drive_slot();
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic wait_sample_slot();
    @(negedge clk_i);
  endtask

  task automatic idle_cycles();
    wait_drive_slot();
    clear_inputs();
    wait_drive_slot();
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("error at %0t ns: %s", $time, what);
      check_errors++;
    end
  endtask

  task automatic report_test(input int index, input string name);
    if (check_errors == errors_at_start) begin
      tests_passed++;
      $display("test %0d %s ok", index, name);
    end else begin
      tests_failed++;
      $display("test %0d %s failed", index, name);
    end
    errors_at_start = check_errors;
  endtask

  // stops at the sample slot of the PC_EXC cycle, if any
  task automatic wait_for_exc_redirect(input int max_cycles, output bit found);
    found = 1'b0;
    for (int i = 0; i < max_cycles && !found; i++) begin
      wait_drive_slot();
      wait_sample_slot();
      found = pc_set_o && (pc_mux_o == PC_EXC);
    end
  endtask

  //////////////////////////////////////////////////
  // scenarios
  //////////////////////////////////////////////////

  task automatic test_boot();
    wait_sample_slot();
    check_equal("pc_set_o", 1'b1, pc_set_o);
    check_equal("pc_mux_o", expected_pc_sel(1'b1, 1'b0, 1'b0), pc_mux_o);
    check_equal("instr_req_o", 1'b0, instr_req_o);
    check_equal("csr_save_cause_o", 1'b0, csr_save_cause_o);
    check_equal("csr_save_if_o", 1'b0, csr_save_if_o);
    check_equal("csr_save_id_o", 1'b0, csr_save_id_o);
    check_equal("csr_restore_mret_o", 1'b0, csr_restore_mret_o);
    check_equal("nmi_mode_o", 1'b0, nmi_mode_o);
    check_equal("flush_id_o", 1'b0, flush_id_o);
    check_equal("id_in_ready_o", 1'b0, id_in_ready_o);
    wait_drive_slot();
    wait_sample_slot();
    check_equal("pc_set_o", 1'b1, pc_set_o);
    check_equal("pc_mux_o", expected_pc_sel(1'b1, 1'b0, 1'b0), pc_mux_o);
    check_equal("instr_req_o", 1'b1, instr_req_o);
    wait_drive_slot();
    wait_sample_slot();
    check_equal("pc_set_o", 1'b0, pc_set_o);
  endtask

  task automatic test_exception();
    logic fetch, plus2, illegal, ecall, ebrk, store, load, compressed;
    {fetch, plus2, illegal, ecall, ebrk, store, load, compressed} = 8'(random_bits(8));
    if (!(fetch | illegal | ecall | ebrk | store | load)) begin
      ecall = 1'b1;
    end
    priv_mode_i = random_bits(1) ? PRIV_LVL_M : PRIV_LVL_U;
    instr_i = random_bits(32);
    pc_id_i = random_bits(32);
    lsu_addr_last_i = random_bits(32);
    instr_compressed_i = 16'(random_bits(16));
    {instr_fetch_err_i, instr_fetch_err_plus2_i, illegal_insn_i} = {fetch, plus2, illegal};
    {ecall_insn_i, ebrk_insn_i, store_err_i, load_err_i} = {ecall, ebrk, store, load};
    instr_is_compressed_i = compressed;
    instr_valid_i = 1'b1;
    // instruction stays in ID through FLUSH
    wait_drive_slot();
    wait_sample_slot();
    check_equal("pc_set_o", 1'b1, pc_set_o);
    check_equal("pc_mux_o", expected_pc_sel(1'b0, 1'b1, 1'b0), pc_mux_o);
    check_equal("csr_save_cause_o", 1'b1, csr_save_cause_o);
    // mepc comes from the ID stage for a synchronous trap
    check_equal("csr_save_id_o", 1'b1, csr_save_id_o);
    check_equal("csr_save_if_o", 1'b0, csr_save_if_o);
    check_equal("flush_id_o", 1'b1, flush_id_o);
    check_equal("exc_cause_o",
                expected_exc_cause(fetch, illegal, ecall, ebrk, store, load, priv_mode_i),
                exc_cause_o);
    check_equal("csr_mtval_o",
                expected_mtval(fetch, plus2, illegal, compressed, ecall, ebrk, store | load,
                               instr_i, pc_id_i, lsu_addr_last_i, instr_compressed_i),
                csr_mtval_o);
  endtask

  task automatic mret_sequence();
    instr_valid_i = 1'b1;
    mret_insn_i = 1'b1;
    wait_drive_slot();
    wait_sample_slot();
    check_equal("pc_set_o", 1'b1, pc_set_o);
    check_equal("pc_mux_o", expected_pc_sel(1'b0, 1'b0, 1'b1), pc_mux_o);
    check_equal("csr_restore_mret_o", 1'b1, csr_restore_mret_o);
    wait_drive_slot();
    clear_inputs();
    wait_sample_slot();
    check_equal("nmi_mode_o", 1'b0, nmi_mode_o);
  endtask

  task automatic test_interrupt();
    bit found, take;
    irq_nm_i = (random_bits(3) == 0);
    irq_fast_i = (random_bits(2) == 0) ? fast_irq_t'(random_bits(NUM_FAST_IRQ)) : '0;
    {irq_external_i, irq_software_i, irq_timer_i, csr_mstatus_mie_i} = 4'(random_bits(4));
    priv_mode_i = random_bits(1) ? PRIV_LVL_M : PRIV_LVL_U;
    take = expected_irq_taken(irq_nm_i, irq_fast_i, irq_external_i, irq_software_i,
                              irq_timer_i, csr_mstatus_mie_i, priv_mode_i);
    wait_for_exc_redirect(10, found);
    if (take) begin
      check_true(found, "enabled interrupt was not taken within 10 cycles");
      check_equal("exc_cause_o", expected_irq_cause(irq_nm_i, irq_fast_i, irq_external_i,
                                                    irq_software_i, irq_timer_i), exc_cause_o);
      check_equal("csr_save_if_o", 1'b1, csr_save_if_o);
      check_equal("csr_save_id_o", 1'b0, csr_save_id_o);
    end else begin
      check_true(!found, "redirect taken for a disabled interrupt");
    end
    // leave the nmi handler again
    if (take && irq_nm_i) begin
      wait_drive_slot();
      clear_inputs();
      mret_sequence();
    end
  endtask

  task automatic test_nmi();
    bit found;
    irq_nm_i = 1'b1;
    wait_for_exc_redirect(10, found);
    check_true(found, "nmi was not taken within 10 cycles");
    check_equal("exc_cause_o", IRQ_CAUSE_NMI, exc_cause_o);
    wait_drive_slot();
    irq_nm_i = 1'b0;
    irq_external_i = 1'b1;
    csr_mstatus_mie_i = 1'b1;
    wait_sample_slot();
    check_equal("nmi_mode_o", 1'b1, nmi_mode_o);
    wait_for_exc_redirect(10, found);
    check_true(!found, "interrupt taken inside the nmi handler");
    wait_drive_slot();
    clear_inputs();
    mret_sequence();
  endtask

  task automatic test_wfi();
    bit found;
    int idx;
    instr_valid_i = 1'b1;
    wfi_insn_i = 1'b1;
    wait_drive_slot();
    wait_drive_slot();
    clear_inputs();
    // WAIT_SLEEP, then SLEEP with no line pending
    for (int i = 0; i < 5; i++) begin
      wait_sample_slot();
      check_equal("ctrl_busy_o", 1'b0, ctrl_busy_o);
      wait_drive_slot();
    end
    idx = int'(random_bits(4) % NUM_FAST_IRQ);
    csr_mstatus_mie_i = 1'b1;
    case (2'(random_bits(2)))
      2'd0: irq_fast_i[idx] = 1'b1;
      2'd1: irq_external_i = 1'b1;
      2'd2: irq_software_i = 1'b1;
      default: irq_timer_i = 1'b1;
    endcase
    wait_for_exc_redirect(8, found);
    check_true(found, "core did not wake up and take the interrupt");
    check_equal("exc_cause_o", expected_irq_cause(1'b0, irq_fast_i, irq_external_i,
                                                  irq_software_i, irq_timer_i), exc_cause_o);
  endtask

  task automatic test_branch_stall();
    logic branch, jump;
    {branch, jump} = 2'(random_bits(2));
    jump = jump | ~branch;
    instr_valid_i = 1'b1;
    branch_set_i = branch;
    jump_set_i = jump;
    wait_sample_slot();
    check_equal("pc_set_o", 1'b1, pc_set_o);
    check_equal("pc_mux_o", expected_pc_sel(1'b0, 1'b0, 1'b0), pc_mux_o);
    check_equal("id_in_ready_o", 1'b1, id_in_ready_o);
    wait_drive_slot();
    {branch_set_i, jump_set_i} = 2'b00;
    stall_id_i = 1'b1;
    wait_sample_slot();
    check_equal("id_in_ready_o", 1'b0, id_in_ready_o);
    check_equal("instr_valid_clear_o", 1'b0, instr_valid_clear_o);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [2:0] kind;
    lfsr_state = 16'd19008;
    clear_inputs();
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;
    test_boot();
    report_test(0, "boot");
    idle_cycles();
    for (int n = 1; n <= NUM_SCENARIOS; n++) begin
      kind = 3'(random_bits(3));
      case (kind)
        3'd0, 3'd1, 3'd2: begin
          test_exception();
          report_test(n, "exception");
        end
        3'd3, 3'd4: begin
          test_interrupt();
          report_test(n, "interrupt");
        end
        3'd5: begin
          test_nmi();
          report_test(n, "nmi");
        end
        3'd6: begin
          test_wfi();
          report_test(n, "wfi");
        end
        default: begin
          test_branch_stall();
          report_test(n, "branch/stall");
        end
      endcase
      idle_cycles();
    end
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- trap_controller.f
+incdir+test
source/trap_ctrl_pkg.sv
source/exc_req_if.sv
source/irq_req_if.sv
source/exc_prio_unit.sv
source/irq_arbiter.sv
source/ctrl_fsm.sv
source/trap_controller.sv
test/tb_trap_controller.sv
